// ==== vlog.f ====
verilog/ipv4_hdr_pkg.sv
verilog/ipv4_tx_cfg_pkg.sv
verilog/ipv4_tx_dispatch.sv
verilog/ipv4_hdr_lane.sv
verilog/ipv4_hdr_serializer.sv
verilog/ipv4_tx_hdr_top.sv
dv/tb_clk_gen.sv
dv/ipv4_tx_hdr_asserts.sv
dv/ipv4_tx_hdr_tb.sv

// ==== Makefile ====
# Verilator flow for the IPv4 transmit header path
# Override from the command line, for example: make sim NUM_LANES=2

VERILATOR ?= verilator
TOP       ?= ipv4_tx_hdr_tb
NUM_LANES ?= 4
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) \
	  -GNUM_LANES=$(NUM_LANES) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
	  -GNUM_LANES=$(NUM_LANES) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/ipv4_tx_hdr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_hdr_tb #(
  parameter int NUM_LANES = ipv4_tx_cfg_pkg::DEFAULT_NUM_LANES
);

  import ipv4_hdr_pkg::*;
  import ipv4_tx_cfg_pkg::*;

  localparam int         DRIVE_DLY  = 2;
  localparam int         WAIT_LIMIT = 2000;  // Cycles
  localparam int         HDR_BITS   = IPV4_HDR_LEN * 8;
  localparam ipv4_addr_t DEV_IP     = 32'h0a00_0001;

  logic          clk;
  logic          fsm_rst;
  logic          req;
  logic          ack;
  ipv4_addr_t    req_dst_ip;
  ipv4_id_t      req_id;
  ipv4_proto_t   req_proto;
  ipv4_ttl_t     req_ttl;
  logic          req_df;
  length_t       req_payload_len;
  logic          mac_busy;
  logic [7:0]    tx_d;
  logic          tx_v;
  logic          tx_sof;
  logic          tx_eof;

  int errors    = 0;
  int checks    = 0;
  int tests     = 0;
  int frames_rx = 0;
  int sof_seen  = 0;

  logic [HDR_BITS-1:0] expected [ipv4_id_t];  // Scoreboard keyed by id
  bit                  used_ids [ipv4_id_t];
  logic [7:0]          rx_bytes [$];

  tb_clk_gen clk_gen_i (.clk(clk), .fsm_rst(fsm_rst));

  ipv4_tx_hdr_top #(
    .NUM_LANES (NUM_LANES)
  ) ipv4_tx_hdr_top_i (
    .clk (clk), .fsm_rst (fsm_rst), .dev_ipv4_addr (DEV_IP),
    .req (req), .ack (ack), .req_dst_ip (req_dst_ip), .req_id (req_id),
    .req_proto (req_proto), .req_ttl (req_ttl), .req_df (req_df),
    .req_payload_len (req_payload_len), .mac_busy (mac_busy),
    .tx_d (tx_d), .tx_v (tx_v), .tx_sof (tx_sof), .tx_eof (tx_eof)
  );

  // Header per RFC 791, checksum taken over the words with its own field at zero
  function automatic logic [HDR_BITS-1:0] model_header(ipv4_addr_t dst, ipv4_id_t id,
      ipv4_proto_t proto, ipv4_ttl_t ttl, logic df, length_t len);
    logic [HDR_BITS-1:0] h;
    int unsigned         sum;
    h = {IPV4_VER_IHL, 8'h00, 16'(IPV4_HDR_LEN) + len, id, 1'b0, df, 14'b0,
         ttl, proto, 16'h0000, DEV_IP, dst};
    sum = 0;
    for (int w = 0; w < IPV4_HDR_LEN / 2; w++) begin
      sum += 32'(h[HDR_BITS-1 - 16*w -: 16]);
    end
    while (sum > 32'hffff) begin
      sum = (sum & 32'hffff) + (sum >> 16);  // End-around carry
    end
    h[HDR_BITS-81 -: 16] = ~sum[15:0];  // Bytes 10 and 11
    return h;
  endfunction

  function automatic void check_hex(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
    end
  endfunction

  function automatic void check_true(bit ok, string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s", msg);
    end
  endfunction

  function automatic void check_frame();
    ipv4_id_t            id;
    logic [HDR_BITS-1:0] exp;
    frames_rx++;
    check_true(rx_bytes.size() == FRAME_LEN,
               $sformatf("Frame had %0d bytes instead of %0d", rx_bytes.size(), FRAME_LEN));
    if (rx_bytes.size() == FRAME_LEN) begin
      id = {rx_bytes[4], rx_bytes[5]};
      check_true(expected.exists(id),
                 $sformatf("Frame with id %h was never requested or arrived twice", id));
      if (expected.exists(id)) begin
        exp = expected[id];
        for (int i = 0; i < FRAME_LEN; i++) begin
          check_hex($sformatf("tx_d byte %0d of id %h", i, id), 32'(rx_bytes[i]),
                    32'(exp[HDR_BITS-1 - 8*i -: 8]));
        end
        expected.delete(id);
      end
    end
  endfunction

  // Frame collector, sampled mid-cycle
  always @(negedge clk) begin
    if (!fsm_rst && tx_v) begin
      if (tx_sof) begin
        sof_seen++;
        rx_bytes.delete();
      end
      rx_bytes.push_back(tx_d);
      if (tx_eof) begin
        check_frame();
      end
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_ack(input logic level);
    int t;
    t = 0;
    while (ack !== level && t < WAIT_LIMIT) begin
      step_cycle();
      t++;
    end
    check_true(ack === level, $sformatf("Timed out waiting for ack to become %0d", level));
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (expected.num() != 0 && t < WAIT_LIMIT) begin
      step_cycle();
      t++;
    end
    check_true(expected.num() == 0,
               $sformatf("Timed out with %0d frames still missing", expected.num()));
    expected.delete();
  endtask

  task automatic load_fields(ipv4_addr_t dst, ipv4_id_t id, ipv4_proto_t proto,
                             ipv4_ttl_t ttl, logic df, length_t len);
    expected[id]    = model_header(dst, id, proto, ttl, df, len);
    used_ids[id]    = 1'b1;
    req_dst_ip      = dst;
    req_id          = id;
    req_proto       = proto;
    req_ttl         = ttl;
    req_df          = df;
    req_payload_len = len;
  endtask

  task automatic send_request(ipv4_addr_t dst, ipv4_id_t id, ipv4_proto_t proto,
                              ipv4_ttl_t ttl, logic df, length_t len);
    load_fields(dst, id, proto, ttl, df, len);
    req = 1'b1;
    wait_ack(1'b1);
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic send_random();
    ipv4_id_t id;
    id = ipv4_id_t'($urandom);
    while (used_ids.exists(id)) begin
      id = ipv4_id_t'($urandom);
    end
    send_request($urandom, id, ipv4_proto_t'($urandom_range(1, 255)),
                 ipv4_ttl_t'($urandom_range(1, 255)), 1'($urandom),
                 length_t'($urandom_range(0, 1480)));
  endtask

  task automatic report_test(string name, int e0);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - e0);
  endtask

  task automatic test_single_header();
    int                  e0;
    int                  f0;
    logic [HDR_BITS-1:0] ref_hdr;
    e0 = errors;
    f0 = frames_rx;
    ref_hdr = model_header(32'hc0a8_0102, 16'h1001, 8'd17, IPV4_DEFAULT_TTL, 1'b1, 16'd100);
    check_hex("model checksum", 32'(ref_hdr[HDR_BITS-81 -: 16]), 32'h5ec9);  // Worked by hand
    send_request(32'hc0a8_0102, 16'h1001, 8'd17, IPV4_DEFAULT_TTL, 1'b1, 16'd100);
    wait_drain();
    check_hex("frames received", 32'(frames_rx - f0), 1);
    report_test("single_header", e0);
  endtask

  task automatic test_handshake();
    int e0;
    int f0;
    e0 = errors;
    f0 = frames_rx;
    repeat (5) begin
      step_cycle();
      check_hex("ack", 32'(ack), 0);  // No req yet
    end
    load_fields(32'hc0a8_0103, 16'h2002, 8'd6, 8'd32, 1'b0, 16'd0);
    req = 1'b1;
    step_cycle();
    check_hex("ack", 32'(ack), 1);  // Edge after req, all lanes free
    wait_ack(1'b1);
    repeat (60) begin  // Req held well past the end of the frame
      step_cycle();
      check_hex("ack", 32'(ack), 1);
    end
    check_hex("frames received", 32'(frames_rx - f0), 1);
    req = 1'b0;
    step_cycle();
    check_hex("ack", 32'(ack), 0);  // Drops on the edge after req falls
    wait_ack(1'b0);
    wait_drain();
    report_test("handshake", e0);
  endtask

  task automatic test_saturation();
    int e0;
    int f0;
    e0 = errors;
    f0 = frames_rx;
    for (int i = 0; i < NUM_LANES + 2; i++) begin
      send_request(32'hc0a8_0200 + i, ipv4_id_t'(32'h3000 + i), 8'd17, IPV4_DEFAULT_TTL,
                   i[0], length_t'(64 * i));
    end
    wait_drain();
    check_hex("frames received", 32'(frames_rx - f0), NUM_LANES + 2);
    report_test("lane_saturation", e0);
  endtask

  task automatic test_mac_busy();
    int e0;
    int f0;
    int s0;
    e0 = errors;
    f0 = frames_rx;
    s0 = sof_seen;
    mac_busy = 1'b1;
    for (int i = 0; i < NUM_LANES; i++) begin  // One per lane, more would never be acked
      send_request(32'hac10_0000 + i, ipv4_id_t'(32'h4000 + i), 8'd1, 8'd255, 1'b1,
                   length_t'(1400 - i));
    end
    repeat (100) begin
      step_cycle();
    end
    check_hex("tx_sof count", 32'(sof_seen - s0), 0);
    mac_busy = 1'b0;
    wait_drain();
    check_hex("frames received", 32'(frames_rx - f0), NUM_LANES);
    report_test("mac_backpressure", e0);
  endtask

  task automatic test_random();
    int e0;
    int f0;
    e0 = errors;
    f0 = frames_rx;
    repeat (30) begin
      send_random();
    end
    wait_drain();
    check_hex("frames received", 32'(frames_rx - f0), 30);
    report_test("random_fields", e0);
  endtask

  initial begin
    int t;
    void'($urandom(17292));
    req             = 1'b0;
    req_dst_ip      = '0;
    req_id          = '0;
    req_proto       = '0;
    req_ttl         = '0;
    req_df          = 1'b0;
    req_payload_len = '0;
    mac_busy        = 1'b0;
    t = 0;
    while (fsm_rst !== 1'b0 && t < 100) begin
      step_cycle();
      t++;
    end
    check_true(fsm_rst === 1'b0, "Reset never released");
    test_single_header();
    test_handshake();
    test_saturation();
    test_mac_busy();
    test_random();
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d frames",
             tests, checks, errors, frames_rx);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : ipv4_tx_hdr_tb

`default_nettype wire

// ==== dv/ipv4_tx_hdr_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_hdr_asserts #(
  parameter int NUM_LANES = ipv4_tx_cfg_pkg::DEFAULT_NUM_LANES
) (
  input logic                 clk,
  input logic                 fsm_rst,
  input logic                 req,
  input logic                 ack,
  input logic                 mac_busy,
  input logic [NUM_LANES-1:0] lane_grant,
  input logic                 tx_v,
  input logic                 tx_sof,
  input logic                 tx_eof
);

  import ipv4_tx_cfg_pkg::*;

  localparam logic [4:0] LAST_POS = 5'(FRAME_LEN - 1);

  logic [4:0] pos;  // Bytes already seen in the current frame

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pos <= '0;
    end else if (tx_sof) begin
      pos <= 5'd1;
    end else if (tx_eof) begin
      pos <= '0;
    end else if (pos != '0) begin
      pos <= pos + 5'd1;
    end
  end

  ack_after_req: assert property (@(posedge clk) disable iff (fsm_rst)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  // Eof lands 19 cycles after sof and nowhere else
  eof_on_last_byte: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_eof == (pos == LAST_POS))
    else $error("tx_eof not on the last byte of a frame");

  v_inside_frame: assert property (@(posedge clk) disable iff (fsm_rst)
    (pos != '0) |-> (tx_v && !tx_sof))
    else $error("tx_v dropped or sof repeated inside a frame");

  v_between_frames: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_v |-> (tx_sof || pos != '0))
    else $error("tx_v high between frames");

  start_needs_idle_mac: assert property (@(posedge clk) disable iff (fsm_rst)
    $rose(|lane_grant) |-> !$past(mac_busy))
    else $error("frame started while mac_busy was high");

endmodule : ipv4_tx_hdr_asserts

bind ipv4_tx_hdr_top ipv4_tx_hdr_asserts #(
  .NUM_LANES (NUM_LANES)
) asserts_i (
  .clk        (clk),
  .fsm_rst    (fsm_rst),
  .req        (req),
  .ack        (ack),
  .mac_busy   (mac_busy),
  .lane_grant (lane_grant),
  .tx_v       (tx_v),
  .tx_sof     (tx_sof),
  .tx_eof     (tx_eof)
);

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic fsm_rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    fsm_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 fsm_rst = 1'b0;  // Just after the edge, ahead of other stimulus
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verilog/ipv4_tx_hdr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_hdr_top #(
  parameter int NUM_LANES = ipv4_tx_cfg_pkg::DEFAULT_NUM_LANES
) (
  input  logic                        clk,
  input  logic                        fsm_rst,
  input  ipv4_hdr_pkg::ipv4_addr_t    dev_ipv4_addr,
  input  logic                        req,
  output logic                        ack,
  input  ipv4_hdr_pkg::ipv4_addr_t    req_dst_ip,
  input  ipv4_hdr_pkg::ipv4_id_t      req_id,
  input  ipv4_hdr_pkg::ipv4_proto_t   req_proto,
  input  ipv4_hdr_pkg::ipv4_ttl_t     req_ttl,
  input  logic                        req_df,
  input  ipv4_hdr_pkg::length_t       req_payload_len,
  input  logic                        mac_busy,
  output logic [7:0]                  tx_d,
  output logic                        tx_v,
  output logic                        tx_sof,
  output logic                        tx_eof
);

  import ipv4_hdr_pkg::*;

  // Shared field bus from the dispatcher
  ipv4_addr_t  ld_dst_ip;
  ipv4_id_t    ld_id;
  ipv4_proto_t ld_proto;
  ipv4_ttl_t   ld_ttl;
  logic        ld_df;
  length_t     ld_payload_len;

  logic [NUM_LANES-1:0]      lane_load;
  logic [NUM_LANES-1:0]      lane_busy;
  logic [NUM_LANES-1:0]      hdr_rdy;
  logic [NUM_LANES-1:0][7:0] hdr_byte;
  logic [NUM_LANES-1:0]      hdr_last;
  logic [NUM_LANES-1:0]      lane_grant;

  ipv4_tx_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) dispatch_i (
    .clk             (clk),
    .fsm_rst         (fsm_rst),
    .req             (req),
    .ack             (ack),
    .req_dst_ip      (req_dst_ip),
    .req_id          (req_id),
    .req_proto       (req_proto),
    .req_ttl         (req_ttl),
    .req_df          (req_df),
    .req_payload_len (req_payload_len),
    .lane_busy       (lane_busy),
    .lane_load       (lane_load),
    .ld_dst_ip       (ld_dst_ip),
    .ld_id           (ld_id),
    .ld_proto        (ld_proto),
    .ld_ttl          (ld_ttl),
    .ld_df           (ld_df),
    .ld_payload_len  (ld_payload_len)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    ipv4_hdr_lane lane_i (
      .clk            (clk),
      .fsm_rst        (fsm_rst),
      .load           (lane_load[i]),
      .ld_dst_ip      (ld_dst_ip),
      .ld_id          (ld_id),
      .ld_proto       (ld_proto),
      .ld_ttl         (ld_ttl),
      .ld_df          (ld_df),
      .ld_payload_len (ld_payload_len),
      .dev_ipv4_addr  (dev_ipv4_addr),
      .busy           (lane_busy[i]),
      .hdr_rdy        (hdr_rdy[i]),
      .grant          (lane_grant[i]),
      .hdr_byte       (hdr_byte[i]),
      .hdr_last       (hdr_last[i])
    );
  end

  ipv4_hdr_serializer #(
    .NUM_LANES (NUM_LANES)
  ) serializer_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .hdr_rdy    (hdr_rdy),
    .hdr_byte   (hdr_byte),
    .hdr_last   (hdr_last),
    .lane_grant (lane_grant),
    .mac_busy   (mac_busy),
    .tx_d       (tx_d),
    .tx_v       (tx_v),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof)
  );

endmodule : ipv4_tx_hdr_top

`default_nettype wire

// ==== verilog/ipv4_hdr_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_serializer #(
  parameter int NUM_LANES = ipv4_tx_cfg_pkg::DEFAULT_NUM_LANES
) (
  input  logic                        clk,
  input  logic                        fsm_rst,
  input  logic [NUM_LANES-1:0]        hdr_rdy,
  input  logic [NUM_LANES-1:0][7:0]   hdr_byte,
  input  logic [NUM_LANES-1:0]        hdr_last,
  output logic [NUM_LANES-1:0]        lane_grant,
  input  logic                        mac_busy,
  output logic [7:0]                  tx_d,
  output logic                        tx_v,
  output logic                        tx_sof,
  output logic                        tx_eof
);

  import ipv4_tx_cfg_pkg::*;

  logic [LANE_IDX_W-1:0] last_served;
  logic [LANE_IDX_W-1:0] hi_idx;
  logic [LANE_IDX_W-1:0] lo_idx;
  logic [LANE_IDX_W-1:0] pick_idx;
  logic                  hi_found;
  logic                  lo_found;
  logic [NUM_LANES-1:0]  pick_oh;
  logic                  active;
  logic                  first_byte;
  logic                  eof_gap;   // Arbitration rests one cycle after eof
  logic [7:0]            cur_byte;
  logic                  cur_last;

  assign active = |lane_grant;

  // Next ready lane above the last one served, else wrap to the lowest
  always_comb begin
    hi_idx   = '0;
    lo_idx   = '0;
    hi_found = 1'b0;
    lo_found = 1'b0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (hdr_rdy[i]) begin
        lo_idx   = LANE_IDX_W'(i);
        lo_found = 1'b1;
        if (i > int'(last_served)) begin
          hi_idx   = LANE_IDX_W'(i);
          hi_found = 1'b1;
        end
      end
    end
    pick_idx = hi_found ? hi_idx : lo_idx;
    for (int i = 0; i < NUM_LANES; i++) begin
      pick_oh[i] = (int'(pick_idx) == i);
    end
  end

  // Grant is one-hot, so a plain select
  always_comb begin
    cur_byte = 8'h00;
    cur_last = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_grant[i]) begin
        cur_byte = hdr_byte[i];
        cur_last = hdr_last[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      lane_grant  <= '0;
      last_served <= LANE_IDX_W'(NUM_LANES - 1);  // Lane 0 goes first
      first_byte  <= 1'b0;
      eof_gap     <= 1'b0;
      tx_v        <= 1'b0;
      tx_sof      <= 1'b0;
      tx_eof      <= 1'b0;
    end else begin
      eof_gap <= 1'b0;
      tx_v    <= active;
      tx_sof  <= active && first_byte;
      tx_eof  <= active && cur_last;
      if (active) begin
        first_byte <= 1'b0;
        if (cur_last) begin
          lane_grant <= '0;
          eof_gap    <= 1'b1;
        end
      end else if (!eof_gap && lo_found && !mac_busy) begin
        lane_grant  <= pick_oh;
        last_served <= pick_idx;
        first_byte  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      tx_d <= cur_byte;
    end
  end

endmodule : ipv4_hdr_serializer

`default_nettype wire

// ==== verilog/ipv4_hdr_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_lane (
  input  logic                        clk,
  input  logic                        fsm_rst,
  input  logic                        load,
  input  ipv4_hdr_pkg::ipv4_addr_t    ld_dst_ip,
  input  ipv4_hdr_pkg::ipv4_id_t      ld_id,
  input  ipv4_hdr_pkg::ipv4_proto_t   ld_proto,
  input  ipv4_hdr_pkg::ipv4_ttl_t     ld_ttl,
  input  logic                        ld_df,
  input  ipv4_hdr_pkg::length_t       ld_payload_len,
  input  ipv4_hdr_pkg::ipv4_addr_t    dev_ipv4_addr,
  output logic                        busy,
  output logic                        hdr_rdy,
  input  logic                        grant,
  output logic [7:0]                  hdr_byte,
  output logic                        hdr_last
);

  import ipv4_hdr_pkg::*;
  import ipv4_tx_cfg_pkg::*;

  localparam int SUM_WORDS = IPV4_HDR_LEN / 2;
  localparam int CNT_W     = $clog2(FRAME_LEN);

  typedef enum logic [1:0] {
    L_IDLE,
    L_SUM,
    L_FOLD,
    L_SEND
  } lane_state_t;

  lane_state_t                  state;
  logic [CNT_W-1:0]             cnt;     // Word count while summing, byte count while sending
  logic [IPV4_HDR_LEN-1:0][7:0] hdr;     // Byte 0 of the header sits at the top
  logic [18:0]                  acc;
  logic [16:0]                  fold_sum;
  logic [15:0]                  folded;
  length_t                      total_len;

  assign total_len = length_t'(IPV4_HDR_LEN) + ld_payload_len;

  // End-around carry, the second add cannot carry again
  assign fold_sum = {1'b0, acc[15:0]} + {14'b0, acc[18:16]};
  assign folded   = fold_sum[15:0] + {15'b0, fold_sum[16]};

  assign hdr_byte = hdr[IPV4_HDR_LEN-1];
  assign hdr_last = (state == L_SEND) && (cnt == CNT_W'(FRAME_LEN - 1));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= L_IDLE;
      cnt     <= '0;
      busy    <= 1'b0;
      hdr_rdy <= 1'b0;
    end else begin
      case (state)
        L_IDLE: begin
          if (load) begin
            busy  <= 1'b1;
            cnt   <= '0;
            state <= L_SUM;
          end
        end
        L_SUM: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(SUM_WORDS - 1)) begin
            state <= L_FOLD;
          end
        end
        L_FOLD: begin
          hdr_rdy <= 1'b1;
          cnt     <= '0;
          state   <= L_SEND;
        end
        default: begin
          if (grant) begin
            cnt <= cnt + 1'b1;
            if (hdr_last) begin  // Last byte leaves this cycle
              busy    <= 1'b0;
              hdr_rdy <= 1'b0;
              state   <= L_IDLE;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      L_IDLE: begin
        if (load) begin
          hdr <= {IPV4_VER_IHL, 8'h00, total_len, ld_id,
                  1'b0, ld_df, 6'b0, 8'h00,  // Flags, fragment offset 0
                  ld_ttl, ld_proto, 16'h0000,
                  dev_ipv4_addr, ld_dst_ip};
          acc <= '0;
        end
      end
      L_SUM: begin
        // Rotate by one word, back in place after the last add
        acc <= acc + {3'b0, hdr[IPV4_HDR_LEN-1 -: 2]};
        hdr <= {hdr[IPV4_HDR_LEN-3:0], hdr[IPV4_HDR_LEN-1 -: 2]};
      end
      L_FOLD: begin
        hdr[9:8] <= ~folded;  // Bytes 10 and 11
      end
      default: begin
        if (grant) begin
          hdr <= {hdr[IPV4_HDR_LEN-2:0], 8'h00};
        end
      end
    endcase
  end

endmodule : ipv4_hdr_lane

`default_nettype wire

// ==== verilog/ipv4_tx_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipv4_tx_dispatch #(
  parameter int NUM_LANES = ipv4_tx_cfg_pkg::DEFAULT_NUM_LANES
) (
  input  logic                        clk,
  input  logic                        fsm_rst,
  input  logic                        req,
  output logic                        ack,
  input  ipv4_hdr_pkg::ipv4_addr_t    req_dst_ip,
  input  ipv4_hdr_pkg::ipv4_id_t      req_id,
  input  ipv4_hdr_pkg::ipv4_proto_t   req_proto,
  input  ipv4_hdr_pkg::ipv4_ttl_t     req_ttl,
  input  logic                        req_df,
  input  ipv4_hdr_pkg::length_t       req_payload_len,
  input  logic [NUM_LANES-1:0]        lane_busy,
  output logic [NUM_LANES-1:0]        lane_load,
  output ipv4_hdr_pkg::ipv4_addr_t    ld_dst_ip,
  output ipv4_hdr_pkg::ipv4_id_t      ld_id,
  output ipv4_hdr_pkg::ipv4_proto_t   ld_proto,
  output ipv4_hdr_pkg::ipv4_ttl_t     ld_ttl,
  output logic                        ld_df,
  output ipv4_hdr_pkg::length_t       ld_payload_len
);

  typedef enum logic [1:0] {
    D_IDLE,
    D_ACKED,     // Load pulse out this cycle
    D_WAIT_DROP  // Ack held until requester lets go
  } disp_state_t;

  disp_state_t          state;
  logic [NUM_LANES-1:0] free_oh;
  logic                 free_found;
  logic                 accept;

  // Lowest free lane wins
  always_comb begin
    free_oh    = '0;
    free_found = 1'b0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (!lane_busy[i]) begin
        free_oh    = '0;
        free_oh[i] = 1'b1;
        free_found = 1'b1;
      end
    end
  end

  assign accept = (state == D_IDLE) && req && free_found;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= D_IDLE;
      ack       <= 1'b0;
      lane_load <= '0;
    end else begin
      lane_load <= '0;  // Single-cycle pulse
      case (state)
        D_IDLE: begin
          if (accept) begin
            ack       <= 1'b1;
            lane_load <= free_oh;
            state     <= D_ACKED;
          end
        end
        D_ACKED: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= D_IDLE;
          end else begin
            state <= D_WAIT_DROP;
          end
        end
        default: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= D_IDLE;
          end
        end
      endcase
    end
  end

  // Field bus, valid alongside lane_load
  always_ff @(posedge clk) begin
    if (accept) begin
      ld_dst_ip      <= req_dst_ip;
      ld_id          <= req_id;
      ld_proto       <= req_proto;
      ld_ttl         <= req_ttl;
      ld_df          <= req_df;
      ld_payload_len <= req_payload_len;
    end
  end

endmodule : ipv4_tx_dispatch

`default_nettype wire

// ==== verilog/ipv4_tx_cfg_pkg.sv ====
`default_nettype none

package ipv4_tx_cfg_pkg;

  localparam int DEFAULT_NUM_LANES = 4;

  // Lane index sized for the largest supported build
  localparam int MAX_LANES  = 8;
  localparam int LANE_IDX_W = $clog2(MAX_LANES);

  // A frame on the MAC side is the bare IPv4 header
  localparam int FRAME_LEN = ipv4_hdr_pkg::IPV4_HDR_LEN;

endpackage : ipv4_tx_cfg_pkg

`default_nettype wire

// ==== verilog/ipv4_hdr_pkg.sv ====
`default_nettype none

package ipv4_hdr_pkg;

  // Protocol field types
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] length_t;    // Byte count
  typedef logic [15:0] ipv4_id_t;
  typedef logic [7:0]  ipv4_proto_t;
  typedef logic [7:0]  ipv4_ttl_t;

  // Version 4 with IHL 5, no options ever sent
  localparam logic [7:0] IPV4_VER_IHL = 8'h45;

  // Fixed header size in bytes
  localparam int IPV4_HDR_LEN = 20;

  localparam ipv4_ttl_t IPV4_DEFAULT_TTL = 8'd64;  // Usual host default

endpackage : ipv4_hdr_pkg

`default_nettype wire
